//--- vlog.f
+incdir+design
design/neuron_math_pkg.sv
design/spike_pkg.sv
design/pool_drive_if.sv
design/rate_to_current.sv
design/izh_neuron_core.sv
design/spike_encoder.sv
design/neuron_pool.sv
verif/tb_neuron_pool.sv

//--- run_sim.sh
#!/bin/sh
# compile the neuron pool testbench with verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f vlog.f \
    --top-module tb_neuron_pool -o sim_tb_neuron_pool
# a $fatal in the testbench gives a nonzero exit status
./obj_dir/sim_tb_neuron_pool

//--- verif/tb_neuron_pool.sv
`timescale 1ns/1ps
`include "neuron_cfg.svh"

module tb_neuron_pool;
    import neuron_math_pkg::*;
    import spike_pkg::*;

    // result of one euler step
    typedef struct packed {
        logic       fired;
        potential_t v;
        potential_t u;
    } step_t;

    // reset 2, floor 8, gain 5, spiking 10, random 40, drain 1
    localparam int TOTAL_SWEEPS = 66;
    localparam int CYCLE_LIMIT  = TOTAL_SWEEPS * `NEURON_COUNT + 100;

    logic         neuron_clk;
    logic         reset_sim;
    float_word_t  f_fr;
    gain_t        i_gain;
    logic         spike;
    spike_id_t    spkid;
    spike_count_t spike_count;
    current_t     i_current_out;

    // 0.0 0.75 1.0 37.9 -5.0 nan 1e9 65535.0
    float_word_t floor_rates [8] = '{
        32'h0000_0000, 32'h3f40_0000, 32'h3f80_0000, 32'h4217_999a,
        32'hc0a0_0000, 32'h7fc0_0000, 32'h4e6e_6b28, 32'h477f_ff00
    };

    neuron_pool neuron_pool_inst (
        .neuron_clk    (neuron_clk),
        .reset_sim     (reset_sim),
        .f_fr          (f_fr),
        .i_gain        (i_gain),
        .spike         (spike),
        .spkid         (spkid),
        .spike_count   (spike_count),
        .i_current_out (i_current_out)
    );

    initial begin
        neuron_clk = 1'b0;
        forever #4 neuron_clk = ~neuron_clk;
    end

    //////////////////////////////
    // reference model
    //////////////////////////////

    // truncate a single float, clamp to the rate ceiling
    function automatic rate_int_t floor_rate(input float_word_t f);
        int     e;
        longint m;
        e = int'(f[30:23]) - 127;
        if (f[31] || (f[30:23] == 8'hff) || (e < 0)) return '0;
        if (e >= 16) return `RATE_MAX;
        m = longint'({1'b1, f[22:0]}) << e;
        m = m >> 23;
        return rate_int_t'(m);
    endfunction

    // rate times gain plus centered noise
    function automatic current_t drive_current(input rate_int_t rate, input gain_t gain,
                                               input logic [31:0] rng);
        longint prod;
        int     noise;
        prod  = longint'(rate) * longint'(gain);
        noise = int'(rng % (1 << `NOISE_BITS)) - (1 << (`NOISE_BITS - 1));
        return current_t'(int'(prod >>> `GAIN_FRAC) + noise);
    endfunction

    function automatic logic [31:0] xorshift_step(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // izhikevich step in Q.8, dt 1/8
    function automatic step_t euler_step(input potential_t v, input potential_t u,
                                         input current_t cur);
        longint sq;
        int     dv;
        int     du;
        step_t  res;
        sq     = longint'(v) * longint'(v);
        dv     = int'(sq >>> `SQ_SHIFT) + 5 * v + `V_REST_OFFSET - u
               + (cur <<< `CURRENT_SHIFT);
        res.v  = v + (dv >>> `DT_SHIFT);
        du     = (((v >>> `B_SHIFT) - u) >>> `A_SHIFT) >>> `DT_SHIFT;
        res.u  = u + du;
        res.fired = (res.v >= `V_PEAK);
        if (res.fired) begin
            res.v = `V_RESET;
            res.u = res.u + `U_JUMP;
        end
        return res;
    endfunction

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    potential_t    v_model [`NEURON_COUNT];
    potential_t    u_model [`NEURON_COUNT];
    logic          model_ready = 1'b0;
    logic          model_running;
    neuron_index_t issue_idx;
    logic [31:0]   rng_model;
    rate_int_t     rate_model;
    gain_t         gain_model;
    // drive to spike, three cycles
    logic          dly_valid [3];
    logic          dly_fire  [3];
    neuron_index_t dly_idx   [3];
    logic          dly_last  [3];
    // expected outputs after each edge
    logic          exp_spike;
    spike_id_t     exp_spkid;
    spike_count_t  exp_count;
    spike_count_t  sweep_acc;
    current_t      exp_current;
    logic          chk_valid;
    neuron_index_t chk_idx;
    potential_t    exp_v;
    potential_t    exp_u;
    int            cycle_count = 0;
    int            total_fires = 0;
    logic          first_drive_seen = 1'b0;
    int unsigned   lcg_state = 32'd44361;

    task automatic stop_on_error();
        $display("TEST FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic reset_model();
        for (int n = 0; n < `NEURON_COUNT; n++) begin
            v_model[n] = `V_RESET;
            u_model[n] = `V_RESET >>> `B_SHIFT;
        end
        for (int s = 0; s < 3; s++) begin
            dly_valid[s] = 1'b0;
        end
        model_ready   = 1'b1;
        model_running = 1'b0;
        issue_idx     = '0;
        rng_model     = `RNG_SEED;
        exp_spike     = 1'b0;
        exp_spkid     = '0;
        exp_count     = '0;
        sweep_acc     = '0;
        exp_current   = '0;
        chk_valid     = 1'b0;
    endtask

    // oldest drive leaves the delay line as spike and count
    task automatic retire_oldest();
        exp_spike = dly_valid[2] && dly_fire[2];
        chk_valid = dly_valid[2];
        if (dly_valid[2]) begin
            chk_idx = dly_idx[2];
            exp_v   = v_model[dly_idx[2]];
            exp_u   = u_model[dly_idx[2]];
            if (dly_fire[2]) begin
                exp_spkid = spike_id_t'(dly_idx[2]);
            end
            if (dly_last[2]) begin
                exp_count = sweep_acc + spike_count_t'(dly_fire[2]);
                sweep_acc = '0;
            end else begin
                sweep_acc = sweep_acc + spike_count_t'(dly_fire[2]);
            end
        end
        for (int s = 2; s > 0; s--) begin
            dly_valid[s] = dly_valid[s-1];
            dly_fire[s]  = dly_fire[s-1];
            dly_idx[s]   = dly_idx[s-1];
            dly_last[s]  = dly_last[s-1];
        end
        dly_valid[0] = 1'b0;
    endtask

    task automatic issue_next();
        step_t res;
        // inputs are taken once per sweep
        if (issue_idx == '0) begin
            rate_model = floor_rate(f_fr);
            gain_model = i_gain;
        end
        exp_current = drive_current(rate_model, gain_model, rng_model);
        rng_model   = xorshift_step(rng_model);
        res         = euler_step(v_model[issue_idx], u_model[issue_idx], exp_current);
        v_model[issue_idx] = res.v;
        u_model[issue_idx] = res.u;
        dly_valid[0] = 1'b1;
        dly_fire[0]  = res.fired;
        dly_idx[0]   = issue_idx;
        dly_last[0]  = (int'(issue_idx) == `NEURON_COUNT - 1);
        issue_idx    = neuron_index_t'((int'(issue_idx) + 1) % `NEURON_COUNT);
    endtask

    // inputs read here still hold their pre-edge values
    always @(posedge neuron_clk) begin
        if (reset_sim) begin
            reset_model();
        end else begin
            cycle_count = cycle_count + 1;
            if (cycle_count >= CYCLE_LIMIT) begin
                $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
                stop_on_error();
            end
            retire_oldest();
            if (model_running) begin
                issue_next();
            end else begin
                // one idle cycle out of reset
                model_running = 1'b1;
            end
        end
    end

    //////////////////////////////
    // compare
    //////////////////////////////

    task automatic check_spike(input logic got_spike, input spike_id_t got_id,
                               input logic want_spike, input spike_id_t want_id);
        if (got_spike !== want_spike) begin
            $display("Mismatch spike got %h exp %h", got_spike, want_spike);
            stop_on_error();
        end
        if (got_id !== want_id) begin
            $display("Mismatch spkid got %h exp %h", got_id, want_id);
            stop_on_error();
        end
    endtask

    task automatic check_count(input spike_count_t got, input spike_count_t want);
        if (got !== want) begin
            $display("Mismatch spike_count got %h exp %h", got, want);
            stop_on_error();
        end
    endtask

    task automatic check_current(input current_t got, input current_t want);
        if (got !== want) begin
            $display("Mismatch i_current_out got %h exp %h", got, want);
            stop_on_error();
        end
    endtask

    task automatic check_potential(input string name, input potential_t got,
                                   input potential_t want);
        if (got !== want) begin
            $display("Mismatch %s got %h exp %h", name, got, want);
            stop_on_error();
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge neuron_clk) begin
        if (model_ready) begin
            check_spike(spike, spkid, exp_spike, exp_spkid);
            check_count(spike_count, exp_count);
            check_current(i_current_out, exp_current);
            if (chk_valid) begin
                // state written back for the neuron that just retired
                check_potential("v_mem", neuron_pool_inst.izh_neuron_core_inst.v_mem[chk_idx],
                                exp_v);
                check_potential("u_mem", neuron_pool_inst.izh_neuron_core_inst.u_mem[chk_idx],
                                exp_u);
            end
            // spikes seen on the output
            if (spike) begin
                total_fires = total_fires + 1;
            end
            if (!first_drive_seen && neuron_pool_inst.drive_bus.drive_valid) begin
                first_drive_seen = 1'b1;
                if (neuron_pool_inst.drive_bus.neuron_index != '0) begin
                    $display("first drive after reset did not carry neuron index 0");
                    stop_on_error();
                end
            end
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    // one full sweep sees exactly one index 0 sample
    task automatic hold_sweep(input float_word_t rate, input gain_t gain);
        @(posedge neuron_clk);
        f_fr   <= rate;
        i_gain <= gain;
        repeat (`NEURON_COUNT - 1) @(posedge neuron_clk);
    endtask

    task automatic random_sweep();
        float_word_t rate;
        gain_t       gain;
        lcg_state = lcg_next(lcg_state);
        // exponent 2^-7 to 2^18, sometimes negative
        rate[31]    = (lcg_state[31:29] == 3'b000);
        rate[30:23] = 8'd120 + 8'(lcg_state[28:24] % 26);
        rate[22:0]  = lcg_state[22:0];
        lcg_state = lcg_next(lcg_state);
        gain = gain_t'(int'(lcg_state[25:16]) - 256);
        hold_sweep(rate, gain);
    endtask

    int spike_base;
    int spike_phase_fires;

    initial begin
        reset_sim = 1'b1;
        f_fr      = '0;
        i_gain    = '0;
        repeat (3) @(posedge neuron_clk);
        reset_sim <= 1'b0;

        // quiet pool after reset
        repeat (2) hold_sweep(32'h0, 32'sd0);

        // float floor at unit gain
        for (int r = 0; r < 8; r++) begin
            hold_sweep(floor_rates[r], 32'sd256);
        end

        // rate 10 with 3.5, 0, -2 and -300/256 gain, then noise only
        hold_sweep(32'h4120_0000, 32'sd896);
        hold_sweep(32'h4120_0000, 32'sd0);
        hold_sweep(32'h4120_0000, -32'sd512);
        hold_sweep(32'h4120_0000, -32'sd300);
        hold_sweep(32'h0, 32'sd0);

        // rate 200 drives the pool over threshold
        spike_base = total_fires;
        repeat (10) hold_sweep(32'h4348_0000, 32'sd256);
        spike_phase_fires = total_fires - spike_base;

        repeat (40) random_sweep();

        // let the pipeline empty
        repeat (`NEURON_COUNT + 4) @(posedge neuron_clk);
        if ((spike_phase_fires == 0) || !first_drive_seen) begin
            $display("spiking phase produced no spikes or no drive was ever issued");
            stop_on_error();
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

//--- design/neuron_pool.sv
`timescale 1ns/1ps

module neuron_pool (
    input  logic                         neuron_clk,
    input  logic                         reset_sim,
    input  neuron_math_pkg::float_word_t f_fr,
    input  neuron_math_pkg::gain_t       i_gain,
    output logic                         spike,
    output spike_pkg::spike_id_t         spkid,
    output spike_pkg::spike_count_t      spike_count,
    output neuron_math_pkg::current_t    i_current_out
);
    import spike_pkg::*;

    //////////////////////////////
    // internal wires
    //////////////////////////////

    // drive from input side to core
    pool_drive_if drive_bus ();

    // core to encoder
    logic          fire;
    neuron_index_t fire_index;
    logic          fire_sweep_last;

    //////////////////////////////
    // blocks
    //////////////////////////////

    // float rate to per neuron current
    rate_to_current rate_to_current_inst (
        .neuron_clk (neuron_clk),
        .reset_sim  (reset_sim),
        .f_fr       (f_fr),
        .i_gain     (i_gain),
        .drive      (drive_bus.source)
    );

    // time multiplexed izhikevich update
    izh_neuron_core izh_neuron_core_inst (
        .neuron_clk      (neuron_clk),
        .reset_sim       (reset_sim),
        .drive           (drive_bus.sink),
        .fire            (fire),
        .fire_index      (fire_index),
        .fire_sweep_last (fire_sweep_last)
    );

    // spike strobe and sweep count
    spike_encoder spike_encoder_inst (
        .neuron_clk      (neuron_clk),
        .reset_sim       (reset_sim),
        .fire            (fire),
        .fire_index      (fire_index),
        .fire_sweep_last (fire_sweep_last),
        .spike           (spike),
        .spkid           (spkid),
        .spike_count     (spike_count)
    );

    // current tap, same cycle as the bus
    assign i_current_out = drive_bus.syn_current;

endmodule

//--- design/spike_encoder.sv
`timescale 1ns/1ps

module spike_encoder (
    input  logic                     neuron_clk,
    input  logic                     reset_sim,
    input  logic                     fire,
    input  spike_pkg::neuron_index_t fire_index,
    input  logic                     fire_sweep_last,
    output logic                     spike,
    output spike_pkg::spike_id_t     spkid,
    output spike_pkg::spike_count_t  spike_count
);
    import spike_pkg::*;

    //////////////////////////////
    // spike strobe
    //////////////////////////////

    // one cycle pulse per fire
    // id holds between spikes
    always_ff @(posedge neuron_clk or posedge reset_sim) begin
        if (reset_sim) begin
            spike <= 1'b0;
            spkid <= '0;
        end else begin
            spike <= fire;
            if (fire) begin
                // zero extend the neuron index
                spkid <= spike_id_t'(fire_index);
            end
        end
    end

    //////////////////////////////
    // per sweep count
    //////////////////////////////

    // running total for the sweep in progress
    spike_count_t sweep_acc;
    spike_count_t fire_inc;

    assign fire_inc = spike_count_t'(fire);

    always_ff @(posedge neuron_clk or posedge reset_sim) begin
        if (reset_sim) begin
            sweep_acc   <= '0;
            spike_count <= '0;
        end else if (fire_sweep_last) begin
            // publish the total, last neuron included
            spike_count <= sweep_acc + fire_inc;
            sweep_acc   <= '0;
        end else begin
            sweep_acc   <= sweep_acc + fire_inc;
        end
    end

endmodule

//--- design/izh_neuron_core.sv
`timescale 1ns/1ps
`include "neuron_cfg.svh"

module izh_neuron_core (
    input  logic                     neuron_clk,
    input  logic                     reset_sim,
    pool_drive_if.sink               drive,
    output logic                     fire,
    output spike_pkg::neuron_index_t fire_index,
    output logic                     fire_sweep_last
);
    import neuron_math_pkg::*;
    import spike_pkg::*;

    //////////////////////////////
    // state memory
    //////////////////////////////

    // membrane potential per neuron
    potential_t v_mem [`NEURON_COUNT];
    // recovery variable per neuron
    potential_t u_mem [`NEURON_COUNT];

    //////////////////////////////
    // stage 1 registers
    //////////////////////////////

    logic          s1_valid;
    logic          s1_last;
    neuron_index_t s1_index;
    current_t      s1_current;
    potential_t    s1_v;
    potential_t    s1_u;

    //////////////////////////////
    // stage 2 arithmetic
    //////////////////////////////

    potential_t         i_scaled;
    logic signed [63:0] v_sq;
    potential_t         sq_term;
    potential_t         lin_term;
    potential_t         dv;
    potential_t         v_next;
    potential_t         du;
    potential_t         u_next;
    logic               spiked;

    // stage 1
    // read v and u for the neuron on the bus
    always_ff @(posedge neuron_clk or posedge reset_sim) begin
        if (reset_sim) begin
            s1_valid <= 1'b0;
            s1_last  <= 1'b0;
        end else begin
            s1_valid <= drive.drive_valid;
            s1_last  <= drive.drive_valid && drive.sweep_last;
        end
    end

    always_ff @(posedge neuron_clk) begin
        s1_index   <= drive.neuron_index;
        s1_current <= drive.syn_current;
        s1_v       <= v_mem[drive.neuron_index];
        s1_u       <= u_mem[drive.neuron_index];
    end

    // stage 2
    // one euler step of the izhikevich model

    // current into the Q.8 scale of v
    assign i_scaled = potential_t'(s1_current) <<< `CURRENT_SHIFT;

    // quadratic term, full width square first
    assign v_sq    = 64'(s1_v) * 64'(s1_v);
    assign sq_term = potential_t'(v_sq >>> `SQ_SHIFT);

    // 5v
    assign lin_term = s1_v * 32'sd5;

    // dv = 0.04v^2 + 5v + 140 - u + I
    assign dv = sq_term + lin_term + `V_REST_OFFSET - s1_u + i_scaled;

    // dt of 1/8
    assign v_next = s1_v + (dv >>> `DT_SHIFT);

    // du = a(bv - u) dt
    assign du = (((s1_v >>> `B_SHIFT) - s1_u) >>> `A_SHIFT) >>> `DT_SHIFT;

    assign u_next = s1_u + du;

    // threshold crossing
    assign spiked = (v_next >= `V_PEAK);

    // write back
    // index differs from the stage 1 read, so no forwarding
    always_ff @(posedge neuron_clk or posedge reset_sim) begin
        if (reset_sim) begin
            for (int n = 0; n < `NEURON_COUNT; n++) begin
                v_mem[n] <= `V_RESET;
                u_mem[n] <= `V_RESET >>> `B_SHIFT;
            end
        end else if (s1_valid) begin
            if (spiked) begin
                // after-spike reset
                v_mem[s1_index] <= `V_RESET;
                u_mem[s1_index] <= u_next + `U_JUMP;
            end else begin
                v_mem[s1_index] <= v_next;
                u_mem[s1_index] <= u_next;
            end
        end
    end

    //////////////////////////////
    // fire outputs
    //////////////////////////////

    // valid two cycles after drive_valid
    always_ff @(posedge neuron_clk or posedge reset_sim) begin
        if (reset_sim) begin
            fire            <= 1'b0;
            fire_index      <= '0;
            fire_sweep_last <= 1'b0;
        end else begin
            fire            <= s1_valid && spiked;
            fire_index      <= s1_index;
            // sweep end marker, whether or not it fired
            fire_sweep_last <= s1_valid && s1_last;
        end
    end

endmodule

//--- design/rate_to_current.sv
`timescale 1ns/1ps
`include "neuron_cfg.svh"

module rate_to_current (
    input  logic                         neuron_clk,
    input  logic                         reset_sim,
    input  neuron_math_pkg::float_word_t f_fr,
    input  neuron_math_pkg::gain_t       i_gain,
    pool_drive_if.source                 drive
);
    import neuron_math_pkg::*;
    import spike_pkg::*;

    //////////////////////////////
    // helpers
    //////////////////////////////

    // float to unsigned integer, truncating
    function automatic rate_int_t float_floor(input float_word_t f);
        logic [7:0]  exp_field;
        logic [7:0]  exp_unbiased;
        logic [23:0] mant;
        logic [4:0]  shamt;
        exp_field    = f[30:23];
        mant         = {1'b1, f[22:0]};
        exp_unbiased = exp_field - 8'd127;
        shamt        = 5'd23 - exp_unbiased[4:0];
        // negative, nan, inf and anything below one
        if (f[31] || (exp_field == 8'hff) || (exp_field < 8'd127)) begin
            return '0;
        end
        // 2^16 and up is past the ceiling
        if (exp_unbiased >= 8'd16) begin
            return `RATE_MAX;
        end
        // at most 16 integer bits left here
        return rate_int_t'(mant >> shamt);
    endfunction

    // xorshift32 with taps 13, 17, 5
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    //////////////////////////////
    // signals
    //////////////////////////////

    sweep_state_t        state;
    neuron_index_t       issue_index;
    logic                issue;
    logic                sweep_start;

    // rate and gain held for the sweep
    rate_int_t           rate_held;
    gain_t               gain_held;
    rate_int_t           rate_floor;
    rate_int_t           rate_now;
    gain_t               gain_now;

    logic [31:0]         rng_state;
    logic [31:0]         rng_next;

    logic signed [63:0]  product;
    current_t            scaled;
    current_t            noise;
    current_t            current_next;

    //////////////////////////////
    // current datapath
    //////////////////////////////

    assign issue       = (state == SWEEP_RUN);
    assign sweep_start = issue && (issue_index == '0);

    // index 0 uses the live inputs, the rest use the held copy
    assign rate_floor = float_floor(f_fr);
    assign rate_now   = sweep_start ? rate_floor : rate_held;
    assign gain_now   = sweep_start ? i_gain : gain_held;

    // rate is unsigned so zero extend before the signed multiply
    assign product = $signed({32'd0, rate_now}) * 64'(gain_now);
    assign scaled  = current_t'(product >>> `GAIN_FRAC);

    // low bits of the generator, shifted to sit around zero
    assign noise = current_t'({1'b0, rng_state[`NOISE_BITS-1:0]})
                 - current_t'(1 << (`NOISE_BITS - 1));

    assign current_next = scaled + noise;
    assign rng_next     = xorshift32(rng_state);

    //////////////////////////////
    // sequencer and drive regs
    //////////////////////////////

    always_ff @(posedge neuron_clk or posedge reset_sim) begin
        if (reset_sim) begin
            state              <= SWEEP_IDLE;
            issue_index        <= '0;
            rng_state          <= `RNG_SEED;
            drive.drive_valid  <= 1'b0;
            drive.neuron_index <= '0;
            drive.syn_current  <= '0;
            drive.sweep_last   <= 1'b0;
        end else begin
            case (state)
                // single idle cycle after reset
                SWEEP_IDLE: state <= SWEEP_RUN;
                SWEEP_RUN:  state <= SWEEP_RUN;
                default:    state <= SWEEP_IDLE;
            endcase
            drive.drive_valid <= issue;
            if (issue) begin
                // index wraps at the pool size by width
                issue_index        <= issue_index + 1'b1;
                rng_state          <= rng_next;
                drive.neuron_index <= issue_index;
                drive.syn_current  <= current_next;
                drive.sweep_last   <= (issue_index == neuron_index_t'(`NEURON_COUNT - 1));
            end
        end
    end

    // sample rate and gain once per sweep
    always_ff @(posedge neuron_clk) begin
        if (sweep_start) begin
            rate_held <= rate_floor;
            gain_held <= i_gain;
        end
    end

endmodule

//--- design/pool_drive_if.sv
`timescale 1ns/1ps

interface pool_drive_if;
    import neuron_math_pkg::*;
    import spike_pkg::*;

    // high on every cycle that carries a neuron
    logic          drive_valid;
    // which neuron this drive belongs to
    neuron_index_t neuron_index;
    // current for that neuron, integer units
    current_t      syn_current;
    // last neuron of the sweep
    logic          sweep_last;

    // input side
    modport source (
        output drive_valid,
        output neuron_index,
        output syn_current,
        output sweep_last
    );

    // neuron core
    modport sink (
        input drive_valid,
        input neuron_index,
        input syn_current,
        input sweep_last
    );

endinterface

//--- design/spike_pkg.sv
`include "neuron_cfg.svh"

package spike_pkg;

    //////////////////////////////
    // spike side types
    //////////////////////////////

    // position of a neuron in the pool
    typedef logic [`NEURON_LOG2-1:0] neuron_index_t;

    // spike id as seen on the output bus
    typedef logic [15:0] spike_id_t;

    // spikes in one sweep
    // one extra bit so a full sweep of fires fits
    typedef logic [`NEURON_LOG2:0] spike_count_t;

    // input sequencer
    // one idle cycle out of reset then run forever
    typedef enum logic {
        SWEEP_IDLE,
        SWEEP_RUN
    } sweep_state_t;

endpackage

//--- design/neuron_math_pkg.sv
package neuron_math_pkg;

    //////////////////////////////
    // float input
    //////////////////////////////

    // raw ieee single word
    // sign in bit 31, exponent in 30:23, mantissa in 22:0
    typedef logic [31:0] float_word_t;

    // floored rate, never negative
    // saturates at the rate ceiling
    typedef logic [31:0] rate_int_t;

    //////////////////////////////
    // fixed point values
    //////////////////////////////

    // synaptic current in integer units
    typedef logic signed [31:0] current_t;

    // membrane potential or recovery
    // eight fractional bits
    typedef logic signed [31:0] potential_t;

    // rate to current gain
    // eight fractional bits, may be negative
    typedef logic signed [31:0] gain_t;

endpackage

//--- design/neuron_cfg.svh
`ifndef NEURON_CFG_SVH
`define NEURON_CFG_SVH

//////////////////////////////
// pool geometry
//////////////////////////////

// log2 of the pool size
`define NEURON_LOG2 4
`define NEURON_COUNT (1 << `NEURON_LOG2)

//////////////////////////////
// fixed point scaling
//////////////////////////////

// integer current up to the Q.8 scale of v
`define CURRENT_SHIFT 8
// fractional bits of i_gain
`define GAIN_FRAC 8
// noise amplitude in bits, centered on zero
`define NOISE_BITS 4
// ceiling of the floored rate
`define RATE_MAX 32'd65535

//////////////////////////////
// regular spiking model, Q.8
//////////////////////////////

`define V_PEAK (32'sd30 * 32'sd256)
`define V_RESET (-32'sd65 * 32'sd256)
`define U_JUMP (32'sd8 * 32'sd256)
`define V_REST_OFFSET (32'sd140 * 32'sd256)
// euler step of 1/8
`define DT_SHIFT 3
// a near 0.02
`define A_SHIFT 6
// b near 0.25
`define B_SHIFT 2
// 0.04 v^2 in Q.8
`define SQ_SHIFT 13

// xorshift start state, never zero
`define RNG_SEED 32'h2545_f491

`endif
